// ==== compile.f ====
axil_pkg.sv
proxy_pkg.sv
reg_req_if.sv
xfer_if.sv
axil_slave.sv
proxy_ctrl.sv
testp_counter.sv
stream_port.sv
axi_proxy.sv
tb_clock.sv
axi_proxy_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module axi_proxy_tb -f compile.f -o sim

out=$(./obj_dir/sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// ==== axi_proxy_tb.sv ====
`timescale 1ns/1ps

module axi_proxy_tb;

    localparam int timeout_cycles = 20000;

    logic         clk;
    logic         resetn;
    logic         sending_testp;
    logic [31:0]  s_axi_awaddr;
    logic         s_axi_awvalid;
    logic         s_axi_awready;
    logic [31:0]  s_axi_wdata;
    logic         s_axi_wvalid;
    logic         s_axi_wready;
    logic [1:0]   s_axi_bresp;
    logic         s_axi_bvalid;
    logic         s_axi_bready;
    logic [31:0]  s_axi_araddr;
    logic         s_axi_arvalid;
    logic         s_axi_arready;
    logic [31:0]  s_axi_rdata;
    logic [1:0]   s_axi_rresp;
    logic         s_axi_rvalid;
    logic         s_axi_rready;
    logic [127:0] out_tdata;
    logic         out_tvalid;
    logic         out_tlast;
    logic         out_tready = 1'b1;
    logic [127:0] in_tdata;
    logic         in_tvalid;
    logic         in_tready;

    // Out stream ready is high in mode 0, random in mode 1 and low in mode 2
    int           tready_mode = 0;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    logic [31:0]  lfsr = 32'hefce_d2b4;

    // Accepted outbound beats in arrival order
    logic [127:0] beat_data[$];
    logic         beat_last[$];
    logic         beat_testp[$];

    tb_clock clock_gen (.clk(clk), .resetn(resetn));

    axi_proxy uut (.*);

    // ====================
    // Helpers
    // ====================
    // Galois LFSR with taps 32 22 2 1
    function automatic logic rand_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) w = {w[30:0], rand_bit()};
        return w;
    endfunction

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Stall pattern on the out stream
    always @(posedge clk) begin
        #1;
        case (tready_mode)
            0: out_tready = 1'b1;
            1: out_tready = rand_bit();
            default: out_tready = 1'b0;
        endcase
    end

    // Record every accepted outbound beat
    always @(posedge clk) begin
        if (resetn && out_tvalid && out_tready) begin
            beat_data.push_back(out_tdata);
            beat_last.push_back(out_tlast);
            beat_testp.push_back(sending_testp);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == timeout_cycles) begin
            $display("Timeout: run still busy after %0d cycles, %0d errors in %0d checks",
                     timeout_cycles, errors, checks);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ====================
    // Bus tasks
    // ====================
    // Drive AW and W together and wait for B
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        @(posedge clk);
        #1;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        @(posedge clk);
        while (!s_axi_awready) @(posedge clk);
        #1;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid) @(posedge clk);
        check_value(128'(s_axi_bresp), 128'(exp_resp), "bresp");
    endtask

    task automatic axil_read(input logic [31:0] addr, input logic [1:0] exp_resp,
                             input logic [31:0] exp_data);
        @(posedge clk);
        #1;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        @(posedge clk);
        while (!s_axi_arready) @(posedge clk);
        #1;
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) @(posedge clk);
        check_value(128'(s_axi_rresp), 128'(exp_resp), "rresp");
        // Read data only means something on OKAY
        if (exp_resp == axil_pkg::resp_okay) begin
            check_value(128'(s_axi_rdata), 128'(exp_data), "rdata");
        end
    endtask

    // Remote device model that checks one request beat and sends one response beat
    task automatic answer_remote(input logic [7:0] mode, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [1:0] resp,
                                 input logic [31:0] rdata);
        logic [127:0] rq;
        logic [127:0] rsp;
        while (beat_data.size() == 0) @(posedge clk);
        rq = beat_data.pop_front();
        check_value(128'(beat_last.pop_front()), 128'd1, "request tlast");
        check_value(128'(beat_testp.pop_front()), 128'd0, "sending_testp on request");
        check_value(128'(rq[proxy_pkg::type_offs +: 8]), 128'd1, "request type");
        check_value(128'(rq[proxy_pkg::mode_offs +: 8]), 128'(mode), "request mode");
        check_value(128'(rq[proxy_pkg::addr_offs +: 32]), 128'(addr), "request address");
        if (mode == 8'd0) begin
            check_value(128'(rq[proxy_pkg::data_offs +: 32]), 128'(wdata), "request data");
        end
        rsp = '0;
        rsp[proxy_pkg::resp_offs +: 2]  = resp;
        rsp[proxy_pkg::data_offs +: 32] = rdata;
        @(posedge clk);
        #1;
        in_tdata  = rsp;
        in_tvalid = 1'b1;
        @(posedge clk);
        while (!in_tready) @(posedge clk);
        #1;
        in_tvalid = 1'b0;
    endtask

    // Wait for a whole burst, check pattern and tlast, then check that it stops
    task automatic collect_testp(input int beats, input int len);
        while (beat_data.size() < beats) @(posedge clk);
        for (int i = 0; i < beats; i++) begin
            check_value(beat_data[i], {16{8'haa}}, "test beat data");
            check_value(128'(beat_last[i]), 128'(((i + 1) % len) == 0), "test beat tlast");
            check_value(128'(beat_testp[i]), 128'd1, "sending_testp during burst");
        end
        repeat (20) @(posedge clk);
        check_value(128'(beat_data.size()), 128'(beats), "test beat count");
        check_value(128'(sending_testp), 128'd0, "sending_testp after burst");
        beat_data.delete();
        beat_last.delete();
        beat_testp.delete();
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_local_regs();
        logic [31:0] val;
        val = rand_word();
        axil_write(32'h0, val, axil_pkg::resp_okay);
        axil_read(32'h0, axil_pkg::resp_okay, val);
        axil_write(32'h8, 32'd7, axil_pkg::resp_okay);
        axil_read(32'h8, axil_pkg::resp_okay, 32'd7);
    endtask

    // Word index 5 is outside the map
    task automatic test_unmapped();
        axil_write(32'h14, rand_word(), axil_pkg::resp_slverr);
        axil_read(32'h14, axil_pkg::resp_slverr, 32'h0);
    endtask

    task automatic test_remote_write();
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  code;
        addr = rand_word();
        axil_write(32'h0, addr, axil_pkg::resp_okay);
        for (int run = 0; run < 2; run++) begin
            data = rand_word();
            code = (run == 0) ? axil_pkg::resp_okay : axil_pkg::resp_slverr;
            fork
                axil_write(32'h4, data, code);
                answer_remote(8'd0, addr, data, code, 32'h0);
            join
        end
    endtask

    task automatic test_remote_read();
        logic [31:0] addr;
        logic [31:0] rdata;
        addr  = rand_word();
        rdata = rand_word();
        axil_write(32'h0, addr, axil_pkg::resp_okay);
        fork
            axil_read(32'h4, axil_pkg::resp_okay, rdata);
            answer_remote(8'd1, addr, 32'h0, axil_pkg::resp_okay, rdata);
        join
    endtask

    task automatic test_testp_burst();
        tready_mode = 1;
        axil_write(32'h8, 32'd3, axil_pkg::resp_okay);
        axil_write(32'hc, 32'd2, axil_pkg::resp_okay);
        collect_testp(6, 3);
        // Length 0 falls back to 18 beats
        axil_write(32'h8, 32'd0, axil_pkg::resp_okay);
        axil_write(32'hc, 32'd1, axil_pkg::resp_okay);
        collect_testp(18, 18);
        axil_write(32'hc, 32'd0, axil_pkg::resp_okay);
        collect_testp(0, 1);
        tready_mode = 0;
    endtask

    // Triggers refused while a stalled burst holds the port
    task automatic test_busy_trigger();
        tready_mode = 2;
        axil_write(32'h8, 32'd3, axil_pkg::resp_okay);
        axil_write(32'hc, 32'd2, axil_pkg::resp_okay);
        repeat (4) @(posedge clk);
        axil_write(32'h4, rand_word(), axil_pkg::resp_slverr);
        axil_write(32'hc, 32'd5, axil_pkg::resp_slverr);
        // First test beat waits on the stalled stream
        check_value(128'(out_tvalid), 128'd1, "out_tvalid held while stalled");
        check_value(out_tdata, {16{8'haa}}, "out_tdata held while stalled");
        check_value(128'(sending_testp), 128'd1, "sending_testp while stalled");
        tready_mode = 0;
        collect_testp(6, 3);
    endtask

    initial begin
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        in_tdata      = '0;
        in_tvalid     = 1'b0;
        @(posedge clk);
        while (!resetn) @(posedge clk);

        test_local_regs();
        test_unmapped();
        test_remote_write();
        test_remote_read();
        test_testp_burst();
        test_busy_trigger();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

// Free running 100 MHz clock and the power-on reset
module tb_clock (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for the first three rising edges
    initial begin
        resetn = 1'b0;
        repeat (3) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

// ==== axi_proxy.sv ====
`timescale 1ns/1ps

module axi_proxy (
    input  logic                           clk,
    input  logic                           resetn,
    output logic                           sending_testp,

    input  logic [axil_pkg::addr_w-1:0]    s_axi_awaddr,
    input  logic                           s_axi_awvalid,
    output logic                           s_axi_awready,
    input  logic [axil_pkg::data_w-1:0]    s_axi_wdata,
    input  logic                           s_axi_wvalid,
    output logic                           s_axi_wready,
    output logic [1:0]                     s_axi_bresp,
    output logic                           s_axi_bvalid,
    input  logic                           s_axi_bready,
    input  logic [axil_pkg::addr_w-1:0]    s_axi_araddr,
    input  logic                           s_axi_arvalid,
    output logic                           s_axi_arready,
    output logic [axil_pkg::data_w-1:0]    s_axi_rdata,
    output logic [1:0]                     s_axi_rresp,
    output logic                           s_axi_rvalid,
    input  logic                           s_axi_rready,

    // Outbound request and test packets
    output logic [proxy_pkg::stream_w-1:0] out_tdata,
    output logic                           out_tvalid,
    output logic                           out_tlast,
    input  logic                           out_tready,

    // Inbound remote response
    input  logic [proxy_pkg::stream_w-1:0] in_tdata,
    input  logic                           in_tvalid,
    output logic                           in_tready
);

    reg_req_if req_bus ();
    xfer_if    xfer_bus ();

    logic cnt_load;
    logic cnt_beat;
    logic cnt_last_beat;
    logic cnt_last_pkt;
    logic cnt_idle;

    axil_slave slave (
        .clk           (clk),
        .resetn        (resetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .req           (req_bus.slave)
    );

    proxy_ctrl ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .req           (req_bus.ctrl),
        .xfer          (xfer_bus.ctrl),
        .sending_testp (sending_testp)
    );

    stream_port port (
        .clk        (clk),
        .resetn     (resetn),
        .xfer       (xfer_bus.port),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tlast  (out_tlast),
        .out_tready (out_tready),
        .in_tdata   (in_tdata),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .load       (cnt_load),
        .beat       (cnt_beat),
        .last_beat  (cnt_last_beat),
        .last_pkt   (cnt_last_pkt),
        .idle       (cnt_idle)
    );

    // Length and count come straight from the held command
    testp_counter counter (
        .clk       (clk),
        .resetn    (resetn),
        .load      (cnt_load),
        .length    (xfer_bus.testp_len),
        .count     (xfer_bus.testp_count),
        .beat      (cnt_beat),
        .last_beat (cnt_last_beat),
        .last_pkt  (cnt_last_pkt),
        .idle      (cnt_idle)
    );

endmodule

// ==== stream_port.sv ====
`timescale 1ns/1ps

module stream_port (
    input  logic                           clk,
    input  logic                           resetn,
    xfer_if.port                           xfer,

    output logic [proxy_pkg::stream_w-1:0] out_tdata,
    output logic                           out_tvalid,
    output logic                           out_tlast,
    input  logic                           out_tready,
    input  logic [proxy_pkg::stream_w-1:0] in_tdata,
    input  logic                           in_tvalid,
    output logic                           in_tready,

    // Test packet counter
    output logic                           load,
    output logic                           beat,
    input  logic                           last_beat,
    input  logic                           last_pkt,
    input  logic                           idle
);

    proxy_pkg::port_state_t state;
    logic                   out_hs;

    assign out_hs    = out_tvalid && out_tready;
    assign beat      = out_hs && (state == proxy_pkg::port_send_beats);
    assign load      = xfer.start && (xfer.kind == proxy_pkg::xfer_testp);
    // Request packets are single beat
    assign out_tlast = (state == proxy_pkg::port_send_beats) ? last_beat
                                                             : (state == proxy_pkg::port_send_req);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= proxy_pkg::port_idle;
            xfer.busy  <= 1'b0;
            out_tvalid <= 1'b0;
            in_tready  <= 1'b0;
        end else begin
            case (state)
                proxy_pkg::port_idle: begin
                    if (xfer.start) begin
                        xfer.busy <= 1'b1;
                        if (xfer.kind == proxy_pkg::xfer_remote) begin
                            out_tdata                              <= '0;
                            out_tdata[proxy_pkg::type_offs +: 8]  <= proxy_pkg::pkt_axi_transact;
                            out_tdata[proxy_pkg::mode_offs +: 8]  <= xfer.mode;
                            out_tdata[proxy_pkg::addr_offs +: 32] <= xfer.addr;
                            out_tdata[proxy_pkg::data_offs +: 32] <= xfer.wdata;
                            out_tvalid                             <= 1'b1;
                            state                                  <= proxy_pkg::port_send_req;
                        end else begin
                            state <= proxy_pkg::port_next_pkt;
                        end
                    end
                end
                proxy_pkg::port_send_req: begin
                    if (out_hs) begin
                        out_tvalid <= 1'b0;
                        in_tready  <= 1'b1;
                        state      <= proxy_pkg::port_wait_resp;
                    end
                end
                // Remote response carries resp and read data
                proxy_pkg::port_wait_resp: begin
                    if (in_tvalid && in_tready) begin
                        xfer.resp  <= axil_pkg::resp_t'(in_tdata[proxy_pkg::resp_offs +: 2]);
                        xfer.rdata <= in_tdata[proxy_pkg::data_offs +: 32];
                        in_tready  <= 1'b0;
                        xfer.busy  <= 1'b0;
                        state      <= proxy_pkg::port_idle;
                    end
                end
                proxy_pkg::port_next_pkt: begin
                    if (idle) begin
                        xfer.busy <= 1'b0;
                        state     <= proxy_pkg::port_idle;
                    end else begin
                        out_tdata  <= {(proxy_pkg::stream_w / 8){proxy_pkg::testp_byte}};
                        out_tvalid <= 1'b1;
                        state      <= proxy_pkg::port_send_beats;
                    end
                end
                // Valid stays up across packets until the final beat
                proxy_pkg::port_send_beats: begin
                    if (out_hs && last_beat && last_pkt) begin
                        out_tvalid <= 1'b0;
                        xfer.busy  <= 1'b0;
                        state      <= proxy_pkg::port_idle;
                    end
                end
                default: state <= proxy_pkg::port_idle;
            endcase
        end
    end

endmodule

// ==== testp_counter.sv ====
`timescale 1ns/1ps

module testp_counter (
    input  logic        clk,
    input  logic        resetn,
    input  logic        load,
    input  logic [7:0]  length,
    input  logic [31:0] count,
    input  logic        beat,
    output logic        last_beat,
    output logic        last_pkt,
    output logic        idle
);

    logic [7:0]  len_q;
    logic [7:0]  beat_left;
    logic [31:0] pkt_left;

    // Idle once no packets remain or right after a count of 0 is loaded
    assign idle      = (pkt_left == 32'd0);
    assign last_pkt  = (pkt_left == 32'd1);
    assign last_beat = (beat_left == 8'd1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pkt_left  <= '0;
            beat_left <= '0;
        end else if (load) begin
            pkt_left  <= count;
            beat_left <= length;
        end else if (beat && !idle) begin
            if (last_beat) begin
                // Packet done so the next one starts
                pkt_left  <= pkt_left - 32'd1;
                beat_left <= len_q;
            end else begin
                beat_left <= beat_left - 8'd1;
            end
        end
    end

    // Packet length kept for each reload
    always_ff @(posedge clk) begin
        if (load) len_q <= length;
    end

endmodule

// ==== proxy_ctrl.sv ====
`timescale 1ns/1ps

module proxy_ctrl (
    input  logic   clk,
    input  logic   resetn,
    reg_req_if.ctrl req,
    xfer_if.ctrl    xfer,
    output logic   sending_testp
);

    proxy_pkg::ctrl_state_t state;
    proxy_pkg::reg_idx_t    word;
    logic [6:0]             offs;
    logic                   access;

    // Software visible registers
    logic [31:0] remote_addr;
    logic [31:0] testp_length;
    logic [31:0] testp_count;

    // Word index inside the 128 byte window
    assign offs   = req.addr[6:0] & axil_pkg::addr_mask;
    assign word   = proxy_pkg::reg_idx_t'(offs[6:2]);
    assign access = req.is_write || req.is_read;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= proxy_pkg::ctrl_idle;
            sending_testp <= 1'b0;
            xfer.start    <= 1'b0;
            req.done      <= 1'b0;
            remote_addr   <= '0;
            testp_length  <= '0;
            testp_count   <= '0;
        end else begin
            xfer.start <= 1'b0;
            req.done   <= 1'b0;
            case (state)
                // ====================
                // Remote access in flight
                // ====================
                proxy_pkg::ctrl_wait_wresp, proxy_pkg::ctrl_wait_rresp: begin
                    // Busy is still low in the cycle of the start pulse
                    if (!xfer.busy && !xfer.start) begin
                        req.done  <= 1'b1;
                        req.resp  <= xfer.resp;
                        req.rdata <= (state == proxy_pkg::ctrl_wait_rresp) ? xfer.rdata : '0;
                        state     <= proxy_pkg::ctrl_idle;
                    end
                end

                // ====================
                // Idle or test packets running
                // ====================
                default: begin
                    // Test burst over once the port drops busy
                    if (state == proxy_pkg::ctrl_testp && !xfer.busy && !xfer.start) begin
                        sending_testp <= 1'b0;
                        state         <= proxy_pkg::ctrl_idle;
                    end
                    if (access) begin
                        req.done  <= 1'b1;
                        req.resp  <= axil_pkg::resp_okay;
                        req.rdata <= '0;
                        case (word)
                            proxy_pkg::reg_remote_addr: begin
                                if (req.is_write) remote_addr <= req.wdata;
                                else req.rdata <= remote_addr;
                            end
                            proxy_pkg::reg_remote_rw: begin
                                if (xfer.busy) begin
                                    req.resp <= axil_pkg::resp_slverr;
                                end else begin
                                    // Answer comes later with the remote response
                                    req.done   <= 1'b0;
                                    xfer.start <= 1'b1;
                                    xfer.kind  <= proxy_pkg::xfer_remote;
                                    xfer.addr  <= remote_addr;
                                    xfer.wdata <= req.wdata;
                                    xfer.mode  <= req.is_read ? proxy_pkg::mode_read
                                                              : proxy_pkg::mode_write;
                                    state      <= req.is_read ? proxy_pkg::ctrl_wait_rresp
                                                              : proxy_pkg::ctrl_wait_wresp;
                                end
                            end
                            proxy_pkg::reg_testp_length: begin
                                if (req.is_write) testp_length <= req.wdata;
                                else req.rdata <= testp_length;
                            end
                            proxy_pkg::reg_testp_count: begin
                                if (req.is_read) begin
                                    req.rdata <= testp_count;
                                end else if (xfer.busy) begin
                                    req.resp <= axil_pkg::resp_slverr;
                                end else begin
                                    testp_count      <= req.wdata;
                                    xfer.start       <= 1'b1;
                                    xfer.kind        <= proxy_pkg::xfer_testp;
                                    xfer.testp_count <= req.wdata;
                                    xfer.testp_len   <= (testp_length[7:0] != 8'd0) ?
                                        testp_length[7:0] : proxy_pkg::default_testp_len;
                                    sending_testp    <= 1'b1;
                                    state            <= proxy_pkg::ctrl_testp;
                                end
                            end
                            default: req.resp <= axil_pkg::resp_slverr;
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// ==== axil_slave.sv ====
`timescale 1ns/1ps

module axil_slave (
    input  logic                        clk,
    input  logic                        resetn,

    input  logic [axil_pkg::addr_w-1:0] s_axi_awaddr,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    input  logic [axil_pkg::data_w-1:0] s_axi_wdata,
    input  logic                        s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic [1:0]                  s_axi_bresp,
    output logic                        s_axi_bvalid,
    input  logic                        s_axi_bready,
    input  logic [axil_pkg::addr_w-1:0] s_axi_araddr,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [axil_pkg::data_w-1:0] s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rvalid,
    input  logic                        s_axi_rready,

    reg_req_if.slave                    req
);

    axil_pkg::req_kind_t pending;
    logic                idle;
    logic                wr_go;
    logic                rd_go;

    // Nothing in flight and no response waiting for the master
    assign idle = (pending == axil_pkg::req_none) && !s_axi_bvalid && !s_axi_rvalid;

    // AW and W go together and writes win over reads
    assign wr_go = idle && s_axi_awvalid && s_axi_wvalid;
    assign rd_go = idle && s_axi_arvalid && !wr_go;

    assign s_axi_awready = wr_go;
    assign s_axi_wready  = wr_go;
    assign s_axi_arready = rd_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending      <= axil_pkg::req_none;
            req.is_write <= 1'b0;
            req.is_read  <= 1'b0;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
        end else begin
            req.is_write <= wr_go;
            req.is_read  <= rd_go;
            if (wr_go) begin
                pending <= axil_pkg::req_write;
            end else if (rd_go) begin
                pending <= axil_pkg::req_read;
            end

            // Controller finished so the matching response channel rises
            if (req.done) begin
                pending <= axil_pkg::req_none;
                if (pending == axil_pkg::req_write) begin
                    s_axi_bvalid <= 1'b1;
                end else begin
                    s_axi_rvalid <= 1'b1;
                end
            end

            if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            if (s_axi_rvalid && s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    // Latched address, data and response payload
    always_ff @(posedge clk) begin
        if (wr_go) begin
            req.addr  <= s_axi_awaddr;
            req.wdata <= s_axi_wdata;
        end else if (rd_go) begin
            req.addr <= s_axi_araddr;
        end
        if (req.done) begin
            s_axi_bresp <= req.resp;
            s_axi_rresp <= req.resp;
            s_axi_rdata <= req.rdata;
        end
    end

endmodule

// ==== xfer_if.sv ====
`timescale 1ns/1ps

// Stream command from the controller to the stream port
interface xfer_if;

    logic                        start;
    proxy_pkg::xfer_kind_t       kind;
    logic [axil_pkg::addr_w-1:0] addr;
    logic [axil_pkg::data_w-1:0] wdata;
    proxy_pkg::axi_mode_t        mode;
    logic [7:0]                  testp_len;
    logic [31:0]                 testp_count;

    // Busy from the cycle after start until the command is finished
    logic                        busy;
    axil_pkg::resp_t             resp;
    logic [axil_pkg::data_w-1:0] rdata;

    modport ctrl (
        output start, kind, addr, wdata, mode, testp_len, testp_count,
        input  busy, resp, rdata
    );

    modport port (
        input  start, kind, addr, wdata, mode, testp_len, testp_count,
        output busy, resp, rdata
    );

endinterface

// ==== reg_req_if.sv ====
`timescale 1ns/1ps

// One decoded register access from the AXI4-Lite slave to the controller
interface reg_req_if;

    // Single cycle request strobes with latched address and data
    logic                        is_write;
    logic                        is_read;
    logic [axil_pkg::addr_w-1:0] addr;
    logic [axil_pkg::data_w-1:0] wdata;

    // Completion pulses once per request
    logic                        done;
    axil_pkg::resp_t             resp;
    logic [axil_pkg::data_w-1:0] rdata;

    modport slave (
        output is_write, is_read, addr, wdata,
        input  done, resp, rdata
    );

    modport ctrl (
        input  is_write, is_read, addr, wdata,
        output done, resp, rdata
    );

endinterface

// ==== proxy_pkg.sv ====
package proxy_pkg;

    // ====================
    // Stream packet layout
    // ====================
    localparam int stream_w = 128;

    // Bit offsets of the packet fields in tdata
    localparam int type_offs = 0;
    localparam int mode_offs = 8;
    localparam int resp_offs = 16;
    localparam int addr_offs = 32;
    localparam int data_offs = 64;

    typedef enum logic [7:0] {
        pkt_axi_transact = 8'd1,
        pkt_test_pattern = 8'd2
    } pkt_type_t;

    typedef enum logic [7:0] {
        mode_write = 8'd0,
        mode_read  = 8'd1
    } axi_mode_t;

    // Test packets carry this byte in every lane
    localparam logic [7:0] testp_byte = 8'haa;
    // Packet length used when software writes 0
    localparam logic [7:0] default_testp_len = 8'd18;

    // ====================
    // Register map
    // ====================
    // Word index within the slave window
    typedef enum logic [4:0] {
        reg_remote_addr  = 5'd0,
        reg_remote_rw    = 5'd1,
        reg_testp_length = 5'd2,
        reg_testp_count  = 5'd3
    } reg_idx_t;

    typedef enum logic [1:0] {
        ctrl_idle, ctrl_wait_wresp, ctrl_wait_rresp, ctrl_testp
    } ctrl_state_t;

    typedef enum logic [2:0] {
        port_idle, port_send_req, port_wait_resp, port_next_pkt, port_send_beats
    } port_state_t;

    typedef enum logic {
        xfer_remote, xfer_testp
    } xfer_kind_t;

endpackage

// ==== axil_pkg.sv ====
package axil_pkg;

    // ====================
    // Bus widths
    // ====================
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // Slave window of 128 bytes holding 32 word registers
    localparam logic [6:0] addr_mask = 7'h7f;

    // Response codes on BRESP and RRESP
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

    // Access held by the slave while the controller works on it
    typedef enum logic [1:0] {
        req_none  = 2'd0,
        req_write = 2'd1,
        req_read  = 2'd2
    } req_kind_t;

endpackage
